// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

   ////////////////////
   // major opcodes, instruction bits 6:2
   ////////////////////
   typedef enum logic [4:0] {
      OPC_OP_IMM = 5'b00100,
      OPC_AUIPC  = 5'b00101,
      OPC_STORE  = 5'b01000,
      OPC_OP     = 5'b01100,
      OPC_LUI    = 5'b01101,
      OPC_BRANCH = 5'b11000,
      OPC_JAL    = 5'b11011
   } rv_opcode_e;

   // funct3 for OP and OP_IMM
   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   // funct3 for BRANCH
   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;

   // word store, the only store width kept
   localparam logic [2:0] F3_SW   = 3'b010;

   // field positions
   localparam int OPC_LSB = 2;
   localparam int RD_LSB  = 7;
   localparam int F3_LSB  = 12;
   localparam int RS1_LSB = 15;
   localparam int RS2_LSB = 20;
   localparam int SUB_BIT = 30;

endpackage

// File: hw/serial_core_pkg.sv
package serial_core_pkg;

   // FETCH waits for the instruction, INIT and RUN are 32-cycle passes
   typedef enum logic [1:0] {
      FETCH,
      INIT,
      RUN,
      MEM
   } core_state_e;

   typedef enum logic [1:0] {
      RD_ADD,
      RD_LT,
      RD_BOOL
   } alu_rd_sel_e;

   typedef enum logic {
      OPB_IMM,
      OPB_RS2
   } op_b_src_e;

   // one bit of a serial adder, returns {carry, sum}
   function automatic logic [1:0] full_add(input logic a, input logic b, input logic c);
      return {(a & b) | (c & (a ^ b)), a ^ b ^ c};
   endfunction

endpackage

// File: hw/core_ctrl_if.sv
`timescale 1ns/1ps

interface core_ctrl_if import serial_core_pkg::*; ();

   logic [4:0]  cnt;
   logic        cnt_en;
   logic        cnt_done;
   core_state_e state;

   logic [4:0]  rs1_addr;
   logic [4:0]  rs2_addr;
   logic [4:0]  rd_addr;
   logic        rd_en;

   logic        imm_bit;

   op_b_src_e   op_b_src;
   logic        alu_sub;
   logic [1:0]  alu_bool_op;
   alu_rd_sel_e alu_rd_sel;
   logic        alu_cmp_uns;
   logic        alu_cmp_neg;

   logic        pc_en;
   logic        jump;
   logic        utype;
   logic        lui;
   logic        jal;

   logic        store_en;
   logic        mem_go;

   modport dec (
      output cnt, cnt_en, cnt_done, state, rs1_addr, rs2_addr, rd_addr, rd_en, imm_bit,
             op_b_src, alu_sub, alu_bool_op, alu_rd_sel, alu_cmp_uns, alu_cmp_neg,
             pc_en, jump, utype, lui, jal, store_en, mem_go
   );

   modport alu (
      input cnt, cnt_en, cnt_done, op_b_src, alu_sub, alu_bool_op, alu_rd_sel,
            alu_cmp_uns, alu_cmp_neg
   );

   modport rf (input cnt, rs1_addr, rs2_addr, rd_addr, rd_en);

   modport pc (input cnt, state, pc_en, jump, imm_bit);

   modport mem (input state, store_en, mem_go);

endinterface

// File: hw/core_decode.sv
`timescale 1ns/1ps

module core_decode import rv_isa_pkg::*; import serial_core_pkg::*; (
   input  logic        clk,
   input  logic        i_rst,
   input  logic        i_ibus_ack,
   input  logic [31:0] i_ibus_rdt,
   input  logic        i_alu_cmp,
   input  logic        i_mem_done,
   core_ctrl_if.dec    ctrl
);

   core_state_e state_r;
   logic [4:0]  cnt_r;
   logic        taken_r;

   rv_opcode_e  opcode;
   logic [2:0]  funct3;
   logic        sub_bit;
   logic [31:0] imm;

   logic fetch_ack, cnt_en, cnt_done;
   logic is_op, is_opimm, is_lui, is_auipc, is_jal, is_branch, is_store;
   logic slt_op, alu_ok;

   // slt, branches and word stores need a first pass
   function automatic logic two_pass(input logic [4:0] opc, input logic [2:0] f3);
      logic arith;
      arith = (opc == OPC_OP) || (opc == OPC_OP_IMM);
      return (arith && (f3 == F3_SLT || f3 == F3_SLTU)) || (opc == OPC_BRANCH) ||
             (opc == OPC_STORE && f3 == F3_SW);
   endfunction

   function automatic logic [31:0] build_imm(input logic [31:0] ins);
      case (ins[OPC_LSB +: 5])
         OPC_STORE:  return {{20{ins[31]}}, ins[31:25], ins[11:7]};
         OPC_BRANCH: return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
         OPC_LUI,
         OPC_AUIPC:  return {ins[31:12], 12'd0};
         OPC_JAL:    return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
         default:    return {{20{ins[31]}}, ins[31:20]};
      endcase
   endfunction

   assign fetch_ack = (state_r == FETCH) & i_ibus_ack;
   assign cnt_en    = (state_r == INIT) | (state_r == RUN);
   assign cnt_done  = cnt_en & (&cnt_r);

   ////////////////////
   // instruction fields
   ////////////////////
   always_ff @(posedge clk) begin
      if (fetch_ack) begin
         opcode        <= rv_opcode_e'(i_ibus_rdt[OPC_LSB +: 5]);
         funct3        <= i_ibus_rdt[F3_LSB +: 3];
         ctrl.rd_addr  <= i_ibus_rdt[RD_LSB +: 5];
         ctrl.rs1_addr <= i_ibus_rdt[RS1_LSB +: 5];
         ctrl.rs2_addr <= i_ibus_rdt[RS2_LSB +: 5];
         sub_bit       <= i_ibus_rdt[SUB_BIT];
         imm           <= build_imm(i_ibus_rdt);
      end else if (cnt_en) begin
         // lsb first, back in place after each pass
         imm <= {imm[0], imm[31:1]};
      end
   end

   ////////////////////
   // state machine and bit counter
   ////////////////////
   always_ff @(posedge clk) begin
      if (i_rst) begin
         state_r <= FETCH;
         cnt_r   <= 5'd0;
         taken_r <= 1'b0;
      end else begin
         if (cnt_en)
            cnt_r <= cnt_r + 5'd1;
         case (state_r)
            FETCH: begin
               if (i_ibus_ack) begin
                  taken_r <= 1'b0;
                  state_r <= two_pass(i_ibus_rdt[OPC_LSB +: 5], i_ibus_rdt[F3_LSB +: 3]) ?
                             INIT : RUN;
               end
            end
            INIT: begin
               if (cnt_done) begin
                  taken_r <= is_branch & i_alu_cmp;
                  state_r <= RUN;
               end
            end
            RUN: begin
               if (cnt_done)
                  state_r <= is_store ? MEM : FETCH;
            end
            MEM: begin
               if (i_mem_done)
                  state_r <= FETCH;
            end
            default: state_r <= FETCH;
         endcase
      end
   end

   ////////////////////
   // control decode
   ////////////////////
   assign is_op     = (opcode == OPC_OP);
   assign is_opimm  = (opcode == OPC_OP_IMM);
   assign is_lui    = (opcode == OPC_LUI);
   assign is_auipc  = (opcode == OPC_AUIPC);
   assign is_jal    = (opcode == OPC_JAL);
   assign is_branch = (opcode == OPC_BRANCH);
   assign is_store  = (opcode == OPC_STORE) & (funct3 == F3_SW);
   assign slt_op    = (is_op | is_opimm) & ((funct3 == F3_SLT) | (funct3 == F3_SLTU));
   // shifts fall through as no-ops
   assign alu_ok    = (is_op | is_opimm) & (funct3[1:0] != 2'b01);

   // for branches the result select picks the compare kind, eq or lt
   always_comb begin
      ctrl.alu_rd_sel  = RD_ADD;
      ctrl.alu_cmp_uns = 1'b0;
      ctrl.alu_cmp_neg = 1'b0;
      if (is_branch) begin
         case (funct3)
            F3_BNE:  ctrl.alu_cmp_neg = 1'b1;
            F3_BLT:  ctrl.alu_rd_sel  = RD_LT;
            F3_BGE: begin
               ctrl.alu_rd_sel  = RD_LT;
               ctrl.alu_cmp_neg = 1'b1;
            end
            F3_BLTU: begin
               ctrl.alu_rd_sel  = RD_LT;
               ctrl.alu_cmp_uns = 1'b1;
            end
            F3_BGEU: begin
               ctrl.alu_rd_sel  = RD_LT;
               ctrl.alu_cmp_uns = 1'b1;
               ctrl.alu_cmp_neg = 1'b1;
            end
            default: ctrl.alu_rd_sel = RD_ADD;
         endcase
      end else if (is_op | is_opimm) begin
         case (funct3)
            F3_SLT:  ctrl.alu_rd_sel = RD_LT;
            F3_SLTU: begin
               ctrl.alu_rd_sel  = RD_LT;
               ctrl.alu_cmp_uns = 1'b1;
            end
            F3_XOR, F3_OR, F3_AND: ctrl.alu_rd_sel = RD_BOOL;
            default: ctrl.alu_rd_sel = RD_ADD;
         endcase
      end
   end

   assign ctrl.cnt         = cnt_r;
   assign ctrl.cnt_en      = cnt_en;
   assign ctrl.cnt_done    = cnt_done;
   assign ctrl.state       = state_r;
   assign ctrl.rd_en       = (state_r == RUN) & (alu_ok | is_lui | is_auipc | is_jal);
   assign ctrl.imm_bit     = imm[0];
   assign ctrl.op_b_src    = (is_op | is_branch) ? OPB_RS2 : OPB_IMM;
   assign ctrl.alu_sub     = slt_op | is_branch | (is_op & (funct3 == F3_ADD) & sub_bit);
   assign ctrl.alu_bool_op = funct3[1:0];
   assign ctrl.pc_en       = (state_r == RUN);
   assign ctrl.jump        = is_jal | taken_r;
   assign ctrl.utype       = is_lui | is_auipc;
   assign ctrl.lui         = is_lui;
   assign ctrl.jal         = is_jal;
   assign ctrl.store_en    = is_store;
   assign ctrl.mem_go      = is_store & (state_r == RUN) & cnt_done;

endmodule

// File: hw/core_alu.sv
`timescale 1ns/1ps

module core_alu import serial_core_pkg::*; (
   input  logic     clk,
   input  logic     i_rst,
   core_ctrl_if.alu ctrl,
   input  logic     i_rs1_bit,
   input  logic     i_rs2_bit,
   input  logic     i_imm_bit,
   output logic     o_rd_bit,
   output logic     o_cmp
);

   logic op_b, cin, sum, cout, bool_bit;
   logic carry_r, eq_r, lt_r;
   logic eq_now, lt_now;

   assign op_b = (ctrl.op_b_src == OPB_RS2) ? i_rs2_bit : i_imm_bit;

   // subtract is a + ~b + 1, the +1 enters as carry at bit 0
   assign cin = (ctrl.cnt == 5'd0) ? ctrl.alu_sub : carry_r;
   assign {cout, sum} = full_add(i_rs1_bit, op_b ^ ctrl.alu_sub, cin);

   always_comb begin
      case (ctrl.alu_bool_op)
         2'b11:   bool_bit = i_rs1_bit & op_b;
         2'b10:   bool_bit = i_rs1_bit | op_b;
         default: bool_bit = i_rs1_bit ^ op_b;
      endcase
   end

   // only valid on the last bit of a pass
   assign eq_now = ((ctrl.cnt == 5'd0) ? 1'b1 : eq_r) & ~(i_rs1_bit ^ op_b);
   assign lt_now = (!ctrl.alu_cmp_uns && (i_rs1_bit ^ op_b)) ? i_rs1_bit : ~cout;

   assign o_cmp = ctrl.alu_cmp_neg ^ ((ctrl.alu_rd_sel == RD_LT) ? lt_now : eq_now);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         carry_r <= 1'b0;
         eq_r    <= 1'b0;
         lt_r    <= 1'b0;
      end else if (ctrl.cnt_en) begin
         carry_r <= cout;
         eq_r    <= eq_now;
         if (ctrl.cnt_done)
            lt_r <= lt_now;
      end
   end

   always_comb begin
      case (ctrl.alu_rd_sel)
         RD_LT:   o_rd_bit = (ctrl.cnt == 5'd0) & lt_r;
         RD_BOOL: o_rd_bit = bool_bit;
         default: o_rd_bit = sum;
      endcase
   end

endmodule

// File: hw/core_regfile.sv
`timescale 1ns/1ps

module core_regfile (
   input  logic    clk,
   input  logic    i_rst,
   core_ctrl_if.rf ctrl,
   input  logic    i_rd_bit,
   output logic    o_rs1_bit,
   output logic    o_rs2_bit
);

   logic [31:0] regs [0:31];
   logic        wr_en;

   // x0 is never written and always reads zero
   assign o_rs1_bit = (ctrl.rs1_addr != 5'd0) & regs[ctrl.rs1_addr][ctrl.cnt];
   assign o_rs2_bit = (ctrl.rs2_addr != 5'd0) & regs[ctrl.rs2_addr][ctrl.cnt];

   assign wr_en = !i_rst && ctrl.rd_en && (ctrl.rd_addr != 5'd0);

   // one bit per cycle, lsb first
   always_ff @(posedge clk) begin
      if (wr_en)
         regs[ctrl.rd_addr][ctrl.cnt] <= i_rd_bit;
   end

endmodule

// File: hw/core_pc.sv
`timescale 1ns/1ps

module core_pc import serial_core_pkg::*; #(
   parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
   input  logic        clk,
   input  logic        i_rst,
   core_ctrl_if.pc     ctrl,
   input  logic        i_ibus_ack,
   output logic [31:0] o_ibus_adr,
   output logic        o_ibus_cyc,
   output logic        o_pc_bit,
   output logic        o_link_bit
);

   logic [31:0] pc_r;
   logic        pc_carry_r;
   logic        link_carry_r;
   logic        four_bit, add_b;
   logic        pc_sum, pc_cout;
   logic        link_cout;

   // constant 4 fed in serially
   assign four_bit = (ctrl.cnt == 5'd2);
   assign add_b    = ctrl.jump ? ctrl.imm_bit : four_bit;

   assign {pc_cout, pc_sum}       = full_add(pc_r[0], add_b, pc_carry_r);
   assign {link_cout, o_link_bit} = full_add(pc_r[0], four_bit, link_carry_r);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         pc_r         <= RESET_PC;
         pc_carry_r   <= 1'b0;
         link_carry_r <= 1'b0;
      end else if ((ctrl.state == FETCH) && i_ibus_ack) begin
         // new instruction, the adders start from zero carry
         pc_carry_r   <= 1'b0;
         link_carry_r <= 1'b0;
      end else if (ctrl.pc_en) begin
         pc_r         <= {pc_sum, pc_r[31:1]};
         pc_carry_r   <= pc_cout;
         link_carry_r <= link_cout;
      end
   end

   // pc_r rotates during RUN, bit 0 is the current bit of the old pc
   assign o_pc_bit   = pc_r[0];
   assign o_ibus_adr = pc_r;
   assign o_ibus_cyc = (ctrl.state == FETCH);

endmodule

// File: hw/core_store_buf.sv
`timescale 1ns/1ps

module core_store_buf import serial_core_pkg::*; (
   input  logic        clk,
   input  logic        i_rst,
   core_ctrl_if.mem    ctrl,
   input  logic        i_adr_bit,
   input  logic        i_dat_bit,
   input  logic        i_dbus_ack,
   output logic [31:0] o_dbus_adr,
   output logic [31:0] o_dbus_dat,
   output logic        o_dbus_we,
   output logic        o_dbus_cyc,
   output logic        o_mem_done
);

   logic [31:0] adr_r;
   logic [31:0] dat_r;
   logic        cyc_r;

   // address comes from the sum in INIT, data from rs2 in RUN
   always_ff @(posedge clk) begin
      if (ctrl.store_en && ctrl.state == INIT)
         adr_r <= {i_adr_bit, adr_r[31:1]};
      if (ctrl.store_en && ctrl.state == RUN)
         dat_r <= {i_dat_bit, dat_r[31:1]};
   end

   always_ff @(posedge clk) begin
      if (i_rst)
         cyc_r <= 1'b0;
      else if (ctrl.mem_go)
         cyc_r <= 1'b1;
      else if (o_mem_done)
         cyc_r <= 1'b0;
   end

   assign o_mem_done = cyc_r & i_dbus_ack;
   assign o_dbus_adr = adr_r;
   assign o_dbus_dat = dat_r;
   assign o_dbus_cyc = cyc_r;
   // stores are the only data bus cycles
   assign o_dbus_we  = cyc_r;

endmodule

// File: hw/serial_core_top.sv
`timescale 1ns/1ps

module serial_core_top #(
   parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
   input  logic        clk,
   input  logic        i_rst,
   // instruction bus
   output logic [31:0] o_ibus_adr,
   output logic        o_ibus_cyc,
   input  logic        i_ibus_ack,
   input  logic [31:0] i_ibus_rdt,
   // data bus
   output logic [31:0] o_dbus_adr,
   output logic [31:0] o_dbus_dat,
   output logic        o_dbus_we,
   output logic        o_dbus_cyc,
   input  logic        i_dbus_ack
);

   core_ctrl_if ctrl_if ();

   wire rs1_bit;
   wire rs2_bit;
   wire alu_rd_bit;
   wire alu_cmp;
   wire pc_bit;
   wire link_bit;
   wire mem_done;

   // operand a is the pc for auipc and zero for lui
   wire op_a_bit = ctrl_if.utype ? (pc_bit & ~ctrl_if.lui) : rs1_bit;
   wire rd_bit   = ctrl_if.jal ? link_bit : alu_rd_bit;

   core_decode decode_i (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_alu_cmp  (alu_cmp),
      .i_mem_done (mem_done),
      .ctrl       (ctrl_if.dec)
   );

   core_alu alu_i (
      .clk       (clk),
      .i_rst     (i_rst),
      .ctrl      (ctrl_if.alu),
      .i_rs1_bit (op_a_bit),
      .i_rs2_bit (rs2_bit),
      .i_imm_bit (ctrl_if.imm_bit),
      .o_rd_bit  (alu_rd_bit),
      .o_cmp     (alu_cmp)
   );

   core_regfile rf_i (
      .clk       (clk),
      .i_rst     (i_rst),
      .ctrl      (ctrl_if.rf),
      .i_rd_bit  (rd_bit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   core_pc #(.RESET_PC(RESET_PC)) pc_i (
      .clk        (clk),
      .i_rst      (i_rst),
      .ctrl       (ctrl_if.pc),
      .i_ibus_ack (i_ibus_ack),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .o_pc_bit   (pc_bit),
      .o_link_bit (link_bit)
   );

   core_store_buf store_i (
      .clk        (clk),
      .i_rst      (i_rst),
      .ctrl       (ctrl_if.mem),
      .i_adr_bit  (alu_rd_bit),
      .i_dat_bit  (rs2_bit),
      .i_dbus_ack (i_dbus_ack),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc),
      .o_mem_done (mem_done)
   );

endmodule

// File: dv/tb_serial_core.sv
`timescale 1ns/1ps

module tb_serial_core import rv_isa_pkg::*; ();

   localparam logic [31:0] RESET_PC      = 32'h0000_0100;
   localparam int          CLK_PERIOD    = 40;
   localparam int          RST_CYCLES    = 4;
   // largest ack delay per bus, used as a bit mask
   localparam int          ACK_DELAY_MAX = 3;

   // instructions issued by each test
   localparam int ARITH_N     = 2 + 9 * 6;
   localparam int COMPARE_N   = 2 + 6 * 12;
   localparam int UPPER_N     = 2 + 3 * 4;
   localparam int FLOW_N      = 2 + 3 * 10 + 4;
   localparam int TOTAL_N     = 2 * ARITH_N + COMPARE_N + UPPER_N + FLOW_N;
   localparam int WATCHDOG_NS =
      (TOTAL_N * (2 * 33 + 2 * ACK_DELAY_MAX + 4) + RST_CYCLES + 8) * CLK_PERIOD;

   logic        clk = 1'b0;
   logic        i_rst;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic        i_ibus_ack;
   logic [31:0] i_ibus_rdt;
   logic [31:0] o_dbus_adr;
   logic [31:0] o_dbus_dat;
   logic        o_dbus_we;
   logic        o_dbus_cyc;
   logic        i_dbus_ack;

   logic [31:0] imem [0:1023];
   logic [31:0] m_regs [0:31];
   logic [31:0] m_pc;
   logic [31:0] st_adr_q [$];
   logic [31:0] st_dat_q [$];

   int   seed = 32'h5dd9ae64;
   int   errors = 0;
   int   bus_errors = 0;
   int   n_instr = 0;
   int   store_dly = 0;
   logic bp_en = 1'b0;

   serial_core_top #(.RESET_PC(RESET_PC)) dut_i (
      .clk        (clk),
      .i_rst      (i_rst),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc),
      .i_dbus_ack (i_dbus_ack)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////
   // instruction encoding
   ////////////////////
   function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd,
                                              input rv_opcode_e opc);
      return {imm, rs1, f3, rd, opc, 2'b11};
   endfunction

   function automatic logic [31:0] rtype_word(input logic sub, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
      return {1'b0, sub, 5'd0, rs2, rs1, f3, rd, OPC_OP, 2'b11};
   endfunction

   function automatic logic [31:0] utype_word(input logic [19:0] imm, input logic [4:0] rd,
                                              input rv_opcode_e opc);
      return {imm, rd, opc, 2'b11};
   endfunction

   function automatic logic [31:0] store_word(input logic [11:0] off, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
      return {off[11:5], rs2, rs1, F3_SW, off[4:0], OPC_STORE, 2'b11};
   endfunction

   function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH, 2'b11};
   endfunction

   function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL, 2'b11};
   endfunction

   ////////////////////
   // architectural model
   ////////////////////
   task automatic model_step(input logic [31:0] ins, output logic st,
                             output logic [31:0] st_adr, output logic [31:0] st_dat);
      logic [31:0] a, b, opb, res, next_pc;
      logic [31:0] imm_i, imm_s, imm_b, imm_j;
      logic [2:0]  f3;
      logic        wr, take;
      a       = m_regs[ins[19:15]];
      b       = m_regs[ins[24:20]];
      f3      = ins[14:12];
      imm_i   = {{20{ins[31]}}, ins[31:20]};
      imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      next_pc = m_pc + 32'd4;
      res     = 32'd0;
      wr      = 1'b0;
      take    = 1'b0;
      st      = 1'b0;
      st_adr  = 32'd0;
      st_dat  = 32'd0;
      case (ins[6:2])
         OPC_OP, OPC_OP_IMM: begin
            opb = (ins[6:2] == OPC_OP_IMM) ? imm_i : b;
            wr  = 1'b1;
            case (f3)
               F3_ADD:  res = (ins[6:2] == OPC_OP && ins[30]) ? a - opb : a + opb;
               F3_SLT:  res = {31'd0, $signed(a) < $signed(opb)};
               F3_SLTU: res = {31'd0, a < opb};
               F3_XOR:  res = a ^ opb;
               F3_OR:   res = a | opb;
               F3_AND:  res = a & opb;
               default: wr = 1'b0;
            endcase
         end
         OPC_LUI: begin
            res = {ins[31:12], 12'd0};
            wr  = 1'b1;
         end
         OPC_AUIPC: begin
            res = m_pc + {ins[31:12], 12'd0};
            wr  = 1'b1;
         end
         OPC_JAL: begin
            res     = m_pc + 32'd4;
            wr      = 1'b1;
            next_pc = m_pc + imm_j;
         end
         OPC_BRANCH: begin
            case (f3)
               F3_BEQ:  take = (a == b);
               F3_BNE:  take = (a != b);
               F3_BLT:  take = ($signed(a) < $signed(b));
               F3_BGE:  take = ($signed(a) >= $signed(b));
               F3_BLTU: take = (a < b);
               F3_BGEU: take = (a >= b);
               default: take = 1'b0;
            endcase
            if (take)
               next_pc = m_pc + imm_b;
         end
         OPC_STORE: begin
            st     = (f3 == F3_SW);
            st_adr = a + imm_s;
            st_dat = b;
         end
         default: wr = 1'b0;
      endcase
      if (wr && ins[11:7] != 5'd0)
         m_regs[ins[11:7]] = res;
      m_pc = next_pc;
   endtask

   task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      errors++;
      $display("error: %s %h, expected %h", name, got, exp);
   endtask

   // answers one fetch and waits for the store of a SW
   task automatic exec_instr(input logic [31:0] ins);
      int          fetch_dly;
      logic        st;
      logic [31:0] e_adr, e_dat, got_adr, got_dat;
      fetch_dly = bp_en ? ($random(seed) & ACK_DELAY_MAX) : 0;
      store_dly = bp_en ? ($random(seed) & ACK_DELAY_MAX) : 0;
      imem[m_pc[11:2]] = ins;
      while (o_ibus_cyc !== 1'b1)
         @(negedge clk);
      repeat (fetch_dly) @(negedge clk);
      if (o_ibus_adr !== m_pc)
         fail_value("o_ibus_adr", o_ibus_adr, m_pc);
      i_ibus_rdt = imem[o_ibus_adr[11:2]];
      i_ibus_ack = 1'b1;
      @(negedge clk);
      i_ibus_ack = 1'b0;
      n_instr++;
      model_step(ins, st, e_adr, e_dat);
      if (st) begin
         while (st_adr_q.size() == 0)
            @(negedge clk);
         got_adr = st_adr_q.pop_front();
         got_dat = st_dat_q.pop_front();
         if (got_adr !== e_adr)
            fail_value("o_dbus_adr", got_adr, e_adr);
         if (got_dat !== e_dat)
            fail_value("o_dbus_dat", got_dat, e_dat);
      end
   endtask

   task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
      logic [31:0] hi;
      // addi sign-extends its 12 bits so the upper part is rounded
      hi = v + 32'h800;
      exec_instr(utype_word(hi[31:12], rd, OPC_LUI));
      exec_instr(itype_word(v[11:0], rd, F3_ADD, rd, OPC_OP_IMM));
   endtask

   ////////////////////
   // directed tests
   ////////////////////
   task automatic check_reset();
      if (o_ibus_cyc !== 1'b1)
         fail_value("o_ibus_cyc", {31'd0, o_ibus_cyc}, 32'd1);
      if (o_ibus_adr !== RESET_PC)
         fail_value("o_ibus_adr", o_ibus_adr, RESET_PC);
      if (o_dbus_cyc !== 1'b0)
         fail_value("o_dbus_cyc", {31'd0, o_dbus_cyc}, 32'd0);
      if (o_dbus_we !== 1'b0)
         fail_value("o_dbus_we", {31'd0, o_dbus_we}, 32'd0);
   endtask

   task automatic arith_ops();
      logic [31:0] a, b, ins;
      int          op;
      load_reg(5'd5, $random(seed));
      for (op = 0; op < 9; op++) begin
         a = $random(seed);
         b = $random(seed);
         load_reg(5'd1, a);
         load_reg(5'd2, b);
         case (op)
            0:       ins = itype_word(b[11:0], 5'd1, F3_ADD, 5'd3, OPC_OP_IMM);
            1:       ins = rtype_word(1'b0, 5'd2, 5'd1, F3_ADD, 5'd3);
            2:       ins = rtype_word(1'b1, 5'd2, 5'd1, F3_ADD, 5'd3);
            3:       ins = rtype_word(1'b0, 5'd2, 5'd1, F3_AND, 5'd3);
            4:       ins = rtype_word(1'b0, 5'd2, 5'd1, F3_OR, 5'd3);
            5:       ins = rtype_word(1'b0, 5'd2, 5'd1, F3_XOR, 5'd3);
            6:       ins = itype_word(b[11:0], 5'd1, F3_AND, 5'd3, OPC_OP_IMM);
            7:       ins = itype_word(b[11:0], 5'd1, F3_OR, 5'd3, OPC_OP_IMM);
            default: ins = itype_word(b[11:0], 5'd1, F3_XOR, 5'd3, OPC_OP_IMM);
         endcase
         exec_instr(ins);
         exec_instr(store_word(a[31:20], 5'd3, 5'd5));
      end
   endtask

   task automatic compares();
      logic [31:0] a, b, ins;
      int          i, k;
      load_reg(5'd5, $random(seed));
      for (i = 0; i < 6; i++) begin
         // operand pairs around the sign boundary and one random pair
         case (i)
            0: begin
               a = 32'h7fff_ffff;
               b = 32'h8000_0000;
            end
            1: begin
               a = 32'h8000_0000;
               b = 32'h7fff_ffff;
            end
            2: begin
               a = 32'h0000_0000;
               b = 32'hffff_ffff;
            end
            3: begin
               a = 32'h0000_07ff;
               b = 32'hffff_f800;
            end
            4: begin
               a = 32'h0000_0005;
               b = 32'h0000_0005;
            end
            default: begin
               a = $random(seed);
               b = $random(seed);
            end
         endcase
         load_reg(5'd1, a);
         load_reg(5'd2, b);
         for (k = 0; k < 4; k++) begin
            case (k)
               0:       ins = rtype_word(1'b0, 5'd2, 5'd1, F3_SLT, 5'd3);
               1:       ins = rtype_word(1'b0, 5'd2, 5'd1, F3_SLTU, 5'd3);
               2:       ins = itype_word(b[11:0], 5'd1, F3_SLT, 5'd3, OPC_OP_IMM);
               default: ins = itype_word(b[11:0], 5'd1, F3_SLTU, 5'd3, OPC_OP_IMM);
            endcase
            exec_instr(ins);
            exec_instr(store_word(12'(k * 4), 5'd3, 5'd5));
         end
      end
   endtask

   task automatic upper_imms();
      logic [31:0] r;
      int          i;
      load_reg(5'd5, $random(seed));
      for (i = 0; i < 3; i++) begin
         r = $random(seed);
         exec_instr(utype_word(r[19:0], 5'd3, OPC_LUI));
         exec_instr(store_word(12'd0, 5'd3, 5'd5));
         exec_instr(utype_word(r[31:12], 5'd3, OPC_AUIPC));
         exec_instr(store_word(12'd4, 5'd3, 5'd5));
      end
   endtask

   task automatic control_flow();
      logic [31:0] a, b;
      logic [12:0] off;
      logic [2:0]  f3;
      int          i, k;
      load_reg(5'd5, $random(seed));
      for (i = 0; i < 3; i++) begin
         case (i)
            0: begin
               a = 32'd5;
               b = 32'd5;
            end
            1: begin
               a = 32'hffff_ffff;
               b = 32'd1;
            end
            default: begin
               a = 32'd1;
               b = 32'hffff_ffff;
            end
         endcase
         load_reg(5'd1, a);
         load_reg(5'd2, b);
         for (k = 0; k < 6; k++) begin
            case (k)
               0:       f3 = F3_BEQ;
               1:       f3 = F3_BNE;
               2:       f3 = F3_BLT;
               3:       f3 = F3_BGE;
               4:       f3 = F3_BLTU;
               default: f3 = F3_BGEU;
            endcase
            // forward and backward targets in turn
            off = k[0] ? 13'h1ff8 : 13'd12;
            exec_instr(branch_word(off, 5'd2, 5'd1, f3));
         end
      end
      exec_instr(jal_word(21'd16, 5'd3));
      exec_instr(store_word(12'd0, 5'd3, 5'd5));
      exec_instr(jal_word(21'h1f_fff4, 5'd3));
      exec_instr(store_word(12'd4, 5'd3, 5'd5));
   endtask

   task automatic back_pressure();
      bp_en = 1'b1;
      arith_ops();
      bp_en = 1'b0;
   endtask

   ////////////////////
   // data bus sink
   ////////////////////
   initial begin
      int   wait_left;
      logic busy;
      i_dbus_ack = 1'b0;
      busy       = 1'b0;
      wait_left  = 0;
      forever begin
         @(negedge clk);
         if (o_ibus_cyc === 1'b1 && o_dbus_cyc === 1'b1) begin
            bus_errors++;
            $display("fetch request raised while a store is still on the data bus");
         end
         if (i_dbus_ack) begin
            i_dbus_ack = 1'b0;
            busy       = 1'b0;
         end else if (o_dbus_cyc === 1'b1) begin
            if (!busy) begin
               busy      = 1'b1;
               wait_left = store_dly;
            end
            if (wait_left == 0) begin
               if (o_dbus_we !== 1'b1) begin
                  bus_errors++;
                  $display("error: o_dbus_we %h, expected 1", o_dbus_we);
               end
               st_adr_q.push_back(o_dbus_adr);
               st_dat_q.push_back(o_dbus_dat);
               i_dbus_ack = 1'b1;
            end else begin
               wait_left--;
            end
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout after %0d ns, the core stopped answering", WATCHDOG_NS);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      i_rst      = 1'b1;
      i_ibus_ack = 1'b0;
      i_ibus_rdt = 32'd0;
      m_pc       = RESET_PC;
      for (int r = 0; r < 32; r++)
         m_regs[r] = 32'd0;
      repeat (RST_CYCLES) @(negedge clk);
      i_rst = 1'b0;
      check_reset();
      arith_ops();
      compares();
      upper_imms();
      control_flow();
      back_pressure();
      if (st_adr_q.size() != 0) begin
         bus_errors++;
         $display("%0d data bus writes came without a matching SW", st_adr_q.size());
      end
      $display("done: %0d instructions, %0d errors (%0d core side, %0d bus side)",
               n_instr, errors + bus_errors, errors, bus_errors);
      if (errors + bus_errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: src.f
hw/rv_isa_pkg.sv
hw/serial_core_pkg.sv
hw/core_ctrl_if.sv
hw/core_decode.sv
hw/core_alu.sv
hw/core_regfile.sv
hw/core_pc.sv
hw/core_store_buf.sv
hw/serial_core_top.sv
dv/tb_serial_core.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the serial core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module tb_serial_core; then
   echo "verilator build failed"
   exit 1
fi

if ! out=$(./obj_dir/Vtb_serial_core); then
   echo "$out"
   echo "simulation exited with an error"
   exit 1
fi
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
fi
exit 1
